// ==== list.f ====
src/fpFormatPkg.sv
src/fpExecPkg.sv
src/fpAlignIf.sv
src/fpSumIf.sv
src/fpOperandAlign.sv
src/fpMantissaAdd.sv
src/fpNormalizePack.sv
src/fpAddUnit.sv
tb/fpAddUnit_assert.sv
tb/fpAddUnitTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the fpAddUnit testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

verilator --binary --timing --assert --top-module fpAddUnitTb \
	--Mdir "$buildDir" -o fpAddUnitSim -f list.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$buildDir/fpAddUnitSim" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
	echo "Simulation exited with status $simStatus"
	exit 1
fi

if grep -qx "Everything OK" "$logFile"; then
	exit 0
else
	echo "Pass message not found in $logFile"
	exit 1
fi

// ==== tb/fpAddUnitTb.sv ====
`timescale 1ns/1ns

module fpAddUnitTb;

	localparam int clockPeriod = 40;
	localparam int nRows = 17;
	localparam int nPairs = 24;
	localparam int maxGap = 3;
	// Reset, two table passes, four ops per pair, drain and margin
	localparam int budgetCycles = 4 + nRows * (2 + maxGap) + 4 * nPairs + 20;

	typedef struct packed {
		fpFormatPkg::halfT a;
		fpFormatPkg::halfT b;
		fpExecPkg::exOpE op;
		fpFormatPkg::halfT res;
	} rowT;

	logic clock;
	logic rstN;
	fpFormatPkg::halfT opA;
	fpFormatPkg::halfT opB;
	fpExecPkg::exOpE opCode;
	fpFormatPkg::halfT result;
	fpExecPkg::exStatusE status;

	rowT rows [nRows];
	fpFormatPkg::halfT symRes [4*nPairs];

	// Ops in flight with the oldest first
	fpFormatPkg::halfT expQ [$];
	fpExecPkg::exOpE opQ [$];
	int slotQ [$]; // -1 table row, -2 idle, else symmetry slot

	int errors;
	int checks;

	fpAddUnit u_dut (
		.clock (clock),
		.rstN (rstN),
		.opA (opA),
		.opB (opB),
		.opCode (opCode),
		.result (result),
		.status (status)
	);

	initial begin
		clock = 1'b0;
		forever #(clockPeriod/2) clock = ~clock;
	end

	initial begin
		#(budgetCycles * clockPeriod);
		$display("Timeout, run did not finish within %0d cycles", budgetCycles);
		$display("Something failed");
		$finish;
	end

	// Result of the op applied two edges ago is on the outputs now
	task automatic checkOutput();
		fpFormatPkg::halfT expRes;
		fpExecPkg::exOpE op;
		fpExecPkg::exStatusE expStatus;
		int slot;
		if (opQ.size() < 2) begin
			return;
		end
		expRes = expQ.pop_front();
		op = opQ.pop_front();
		slot = slotQ.pop_front();
		expStatus = (op == fpExecPkg::opNone) ? fpExecPkg::statusReady :
			fpExecPkg::statusOk;
		checks++;
		if (status !== expStatus) begin
			errors++;
			$display("ERR t=%0t status expected %b got %b", $time, expStatus, status);
		end
		if (slot == -1 && op != fpExecPkg::opNone) begin
			checks++;
			if (result !== expRes) begin
				errors++;
				$display("ERR t=%0t result expected %h got %h", $time, expRes, result);
			end
		end else if (slot >= 0) begin
			symRes[slot] = result;
		end
	endtask

	task automatic applyOp(input fpFormatPkg::halfT a, input fpFormatPkg::halfT b,
			input fpExecPkg::exOpE op, input fpFormatPkg::halfT expRes, input int slot);
		@(posedge clock);
		#1;
		checkOutput();
		#1;
		opA = a;
		opB = b;
		opCode = op;
		expQ.push_back(expRes);
		opQ.push_back(op);
		slotQ.push_back(slot);
	endtask

	task automatic idleCycle();
		applyOp('0, '0, fpExecPkg::opNone, '0, -2);
	endtask

	initial begin
		logic [31:0] r;
		fpFormatPkg::halfT a;
		fpFormatPkg::halfT b;
		int gap;
		int i;
		int p;
		void'($urandom(32'hb5f9_32d0));
		errors = 0;
		checks = 0;
		rstN = 1'b1;
		opA = '0;
		opB = '0;
		opCode = fpExecPkg::opNone;

		rows = '{
			'{16'h3C00, 16'h3C00, fpExecPkg::opAdd, 16'h4000},
			'{16'h4000, 16'h3C00, fpExecPkg::opSub, 16'h3C00},
			'{16'h3E00, 16'h3400, fpExecPkg::opAddAlt, 16'h3F00},
			'{16'h3C00, 16'h3800, fpExecPkg::opAdd, 16'h3E00},
			'{16'h4000, 16'h3E00, fpExecPkg::opSub, 16'h3800},
			'{16'h5000, 16'h1000, fpExecPkg::opAdd, 16'h5000}, // Shift past maxShift
			'{16'h1000, 16'h5000, fpExecPkg::opSub, 16'hD000},
			'{16'h3C00, 16'h3C00, fpExecPkg::opNone, 16'h0000},
			'{16'h3C00, 16'h3C00, fpExecPkg::opSub, 16'h0000},
			'{16'h3C01, 16'h3C00, fpExecPkg::opSub, 16'h1400}, // Ten place left shift
			'{16'hBC00, 16'h4000, fpExecPkg::opAdd, 16'h3C00},
			'{16'h4000, 16'hC200, fpExecPkg::opAddAlt, 16'hBC00},
			'{16'h7BFF, 16'h7BFF, fpExecPkg::opAdd, 16'h7C00},
			'{16'hFBFF, 16'hFBFF, fpExecPkg::opAdd, 16'hFC00},
			'{16'h7BFF, 16'hFBFF, fpExecPkg::opSub, 16'h7C00},
			'{16'h0401, 16'h0400, fpExecPkg::opSub, 16'h0000}, // Underflow
			'{16'h8401, 16'h0400, fpExecPkg::opAdd, 16'h0000}
		};

		#5 rstN = 1'b0;
		repeat (2) @(posedge clock);
		#2 rstN = 1'b1;
		checks++;
		if (status !== fpExecPkg::statusReady) begin
			errors++;
			$display("ERR t=%0t status expected %b got %b", $time,
				fpExecPkg::statusReady, status);
		end

		// Back to back rows keep two ops in flight
		for (i = 0; i < nRows; i++) begin
			applyOp(rows[i].a, rows[i].b, rows[i].op, rows[i].res, -1);
		end

		for (i = 0; i < nRows; i++) begin
			r = $urandom;
			gap = int'(r % (maxGap + 1));
			repeat (gap) idleCycle();
			applyOp(rows[i].a, rows[i].b, rows[i].op, rows[i].res, -1);
		end

		for (p = 0; p < nPairs; p++) begin
			r = $urandom;
			a = r[15:0];
			r = $urandom;
			b = r[15:0];
			applyOp(a, b, fpExecPkg::opAdd, '0, 4*p);
			applyOp(b, a, fpExecPkg::opAdd, '0, 4*p + 1);
			applyOp(a, b, fpExecPkg::opSub, '0, 4*p + 2);
			applyOp(a, {~b[15], b[14:0]}, fpExecPkg::opAdd, '0, 4*p + 3);
		end

		// Drain the last two ops
		repeat (2) idleCycle();

		for (p = 0; p < nPairs; p++) begin
			checks++;
			if (symRes[4*p] !== symRes[4*p + 1]) begin
				errors++;
				$display("ERR t=%0t result add(a,b) %h add(b,a) %h", $time,
					symRes[4*p], symRes[4*p + 1]);
			end
			checks++;
			if (symRes[4*p + 2] !== symRes[4*p + 3]) begin
				errors++;
				$display("ERR t=%0t result sub(a,b) %h add(a,-b) %h", $time,
					symRes[4*p + 2], symRes[4*p + 3]);
			end
		end

		$display("Checks run %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule

// ==== tb/fpAddUnit_assert.sv ====
`timescale 1ns/1ns

module fpAddUnitAssert (
	input logic clock,
	input logic rstN,
	input fpExecPkg::exOpE opCode,
	input fpFormatPkg::halfT result,
	input fpExecPkg::exStatusE status
);

	// Two register stages between an op and its status
	property opGivesOk;
		@(posedge clock) disable iff (!rstN)
		(opCode != fpExecPkg::opNone) |-> ##2 (status == fpExecPkg::statusOk);
	endproperty

	property noneGivesReady;
		@(posedge clock) disable iff (!rstN)
		(opCode == fpExecPkg::opNone) |-> ##2 (status == fpExecPkg::statusReady);
	endproperty

	// All ones exponent may only carry a zero fraction
	property noNanResult;
		@(posedge clock) disable iff (!rstN)
		(status == fpExecPkg::statusOk) |->
			!((result[fpFormatPkg::fracW +: fpFormatPkg::expW] == '1) &&
			(result[fpFormatPkg::fracW-1:0] != '0));
	endproperty

	property idleInReset;
		@(posedge clock) !rstN |-> (status == fpExecPkg::statusReady);
	endproperty

	assertOpOk: assert property (opGivesOk)
		else $error("Status not valid two edges after an op");
	assertNoneReady: assert property (noneGivesReady)
		else $error("Status valid two edges after an idle cycle");
	assertNoNan: assert property (noNanResult)
		else $error("Result carries a NaN pattern");
	assertResetIdle: assert property (idleInReset)
		else $error("Status not idle during reset");

endmodule

bind fpAddUnit fpAddUnitAssert uAssert (
	.clock (clock),
	.rstN (rstN),
	.opCode (opCode),
	.result (result),
	.status (status)
);

// ==== src/fpAddUnit.sv ====
`timescale 1ns/1ns

module fpAddUnit (
	input logic clock,
	input logic rstN,
	input fpFormatPkg::halfT opA,
	input fpFormatPkg::halfT opB,
	input fpExecPkg::exOpE opCode,
	output fpFormatPkg::halfT result,
	output fpExecPkg::exStatusE status
);

	fpAlignIf alignBus ();
	fpSumIf sumBus ();

	// Stage 1, unpack and align
	fpOperandAlign uAlign (
		.clock (clock),
		.rstN (rstN),
		.opA (opA),
		.opB (opB),
		.opCode (opCode),
		.alignOut (alignBus.source)
	);

	// Stage 2, significand add or subtract
	fpMantissaAdd uAdd (
		.clock (clock),
		.rstN (rstN),
		.alignIn (alignBus.sink),
		.sumOut (sumBus.source)
	);

	fpNormalizePack uPack (
		.sumIn (sumBus.sink),
		.result (result),
		.status (status)
	);

endmodule

// ==== src/fpNormalizePack.sv ====
`timescale 1ns/1ns

module fpNormalizePack (
	fpSumIf.sink sumIn,
	output fpFormatPkg::halfT result,
	output fpExecPkg::exStatusE status
);

	// Zeros above the hidden one position, 11 for an all zero input
	function automatic logic [3:0] countLeadZeros(input fpFormatPkg::sigT s);
		logic [3:0] n;
		logic found;
		integer i;
		n = 4'd0;
		found = 1'b0;
		for (i = fpFormatPkg::fracW; i >= 0; i = i - 1) begin
			if (!found && !s[i]) begin
				n = n + 1'b1;
			end else begin
				found = 1'b1;
			end
		end
		return n;
	endfunction

	logic [3:0] leadZeros;
	logic packSign;
	fpFormatPkg::sigT normSig;
	fpFormatPkg::expWideT expAdj;
	fpFormatPkg::expFieldT expField;
	logic [fpFormatPkg::fracW-1:0] frac;

	always_comb begin
		leadZeros = countLeadZeros(sumIn.sig);
		normSig = sumIn.sig << leadZeros;
		packSign = sumIn.sign;

		if (sumIn.sig[fpFormatPkg::fracW+1]) begin // Carry out of the add
			expAdj = sumIn.exp + 1'b1;
			frac = sumIn.sig[fpFormatPkg::fracW:1]; // Truncated
		end else if (sumIn.sig == '0) begin
			expAdj = '0;
			frac = '0;
			packSign = 1'b0; // Exact zero is always positive
		end else begin
			expAdj = sumIn.exp - leadZeros;
			frac = normSig[fpFormatPkg::fracW-1:0];
		end

		expField = expAdj[fpFormatPkg::expW-1:0];

		if (expAdj[fpFormatPkg::expW]) begin
			// Wrapped below zero keeps bit 4 set, a carry past 31 does not
			if (expAdj[fpFormatPkg::expW-1]) begin
				result = '0;
			end else begin
				result = {packSign, fpFormatPkg::infMag};
			end
		end else if (expField == '1) begin
			result = {packSign, fpFormatPkg::infMag}; // Never emit a NaN pattern
		end else begin
			result = {packSign, expField, frac};
		end

		status = sumIn.active ? fpExecPkg::statusOk : fpExecPkg::statusReady;
	end

endmodule

// ==== src/fpMantissaAdd.sv ====
`timescale 1ns/1ns

module fpMantissaAdd (
	input logic clock,
	input logic rstN,
	fpAlignIf.sink alignIn,
	fpSumIf.source sumOut
);

	logic sumSign;
	fpFormatPkg::expWideT sumExp;
	fpFormatPkg::sigT sumSig;

	always_comb begin
		if (alignIn.expGtAB) begin
			sumSign = alignIn.signA;
			sumExp = alignIn.expA;
			if (alignIn.effSub) begin
				sumSig = alignIn.sigA - alignIn.shiftedB;
			end else begin
				sumSig = alignIn.sigA + alignIn.shiftedB;
			end
		end else if (alignIn.expGtBA) begin
			sumSign = alignIn.signB;
			sumExp = alignIn.expB;
			if (alignIn.effSub) begin
				sumSig = alignIn.sigB - alignIn.shiftedA;
			end else begin
				sumSig = alignIn.sigB + alignIn.shiftedA;
			end
		end else if (alignIn.sigGtAB) begin // Equal exponents, A larger
			sumSign = alignIn.signA;
			sumExp = alignIn.expA;
			sumSig = alignIn.effSub ? alignIn.diffAB : alignIn.sumAB;
		end else begin
			// B larger or equal, exact cancellation lands here
			sumSign = alignIn.signB;
			sumExp = alignIn.expB;
			sumSig = alignIn.effSub ? alignIn.diffBA : alignIn.sumAB;
		end
	end

	always_ff @(posedge clock) begin
		sumOut.sign <= sumSign;
		sumOut.exp <= sumExp;
		sumOut.sig <= sumSig;
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			sumOut.active <= 1'b0;
		end else begin
			sumOut.active <= alignIn.active;
		end
	end

endmodule

// ==== src/fpOperandAlign.sv ====
`timescale 1ns/1ns

module fpOperandAlign (
	input logic clock,
	input logic rstN,
	input fpFormatPkg::halfT opA,
	input fpFormatPkg::halfT opB,
	input fpExecPkg::exOpE opCode,
	fpAlignIf.source alignOut
);

	logic signA;
	logic signB;
	fpFormatPkg::expWideT expA;
	fpFormatPkg::expWideT expB;
	fpFormatPkg::expWideT expDiffAB;
	fpFormatPkg::expWideT expDiffBA;
	fpFormatPkg::sigT sigA;
	fpFormatPkg::sigT sigB;
	fpFormatPkg::sigT shiftA;
	fpFormatPkg::sigT shiftB;
	fpFormatPkg::sigT sigDiffAB;
	fpFormatPkg::sigT sigDiffBA;
	fpFormatPkg::sigT sigSum;

	always_comb begin
		signA = opA[fpFormatPkg::halfW-1];
		signB = opB[fpFormatPkg::halfW-1] ^ ~opCode[0]; // Subtract adds the negated B

		expA = {1'b0, opA[fpFormatPkg::fracW +: fpFormatPkg::expW]};
		expB = {1'b0, opB[fpFormatPkg::fracW +: fpFormatPkg::expW]};

		// Hidden one always present, guard bit clear
		sigA = {2'b01, opA[fpFormatPkg::fracW-1:0]};
		sigB = {2'b01, opB[fpFormatPkg::fracW-1:0]};

		expDiffAB = expA - expB;
		expDiffBA = expB - expA;

		// Negative differences wrap large and shift to zero as well
		shiftA = (expDiffBA <= fpFormatPkg::maxShift) ? (sigA >> expDiffBA) : '0;
		shiftB = (expDiffAB <= fpFormatPkg::maxShift) ? (sigB >> expDiffAB) : '0;

		sigDiffAB = sigA - sigB;
		sigDiffBA = sigB - sigA;
		sigSum = sigA + sigB;
	end

	always_ff @(posedge clock) begin
		alignOut.signA <= signA;
		alignOut.signB <= signB;
		alignOut.effSub <= signA ^ signB;

		alignOut.expA <= expA;
		alignOut.expB <= expB;
		alignOut.sigA <= sigA;
		alignOut.sigB <= sigB;
		alignOut.shiftedA <= shiftA;
		alignOut.shiftedB <= shiftB;

		alignOut.diffAB <= sigDiffAB;
		alignOut.diffBA <= sigDiffBA;
		alignOut.sumAB <= sigSum;

		// Sign of the opposite difference tells which side is larger
		alignOut.expGtAB <= expDiffBA[fpFormatPkg::expW];
		alignOut.expGtBA <= expDiffAB[fpFormatPkg::expW];
		alignOut.sigGtAB <= sigDiffBA[fpFormatPkg::fracW+1];
	end

	always_ff @(posedge clock or negedge rstN) begin
		if (!rstN) begin
			alignOut.active <= 1'b0;
		end else begin
			alignOut.active <= (opCode != fpExecPkg::opNone);
		end
	end

endmodule

// ==== src/fpSumIf.sv ====
`timescale 1ns/1ns

interface fpSumIf;

	logic sign;
	fpFormatPkg::expWideT exp;
	fpFormatPkg::sigT sig; // Raw sum, not yet normalized
	logic active;

	modport source (
		output sign,
		output exp,
		output sig,
		output active
	);

	modport sink (
		input sign,
		input exp,
		input sig,
		input active
	);

endinterface

// ==== src/fpAlignIf.sv ====
`timescale 1ns/1ns

interface fpAlignIf;

	logic signA;
	logic signB; // Already flipped for subtract
	logic effSub;

	fpFormatPkg::expWideT expA;
	fpFormatPkg::expWideT expB;

	fpFormatPkg::sigT sigA;
	fpFormatPkg::sigT sigB;
	fpFormatPkg::sigT shiftedA; // Aligned to expB
	fpFormatPkg::sigT shiftedB; // Aligned to expA

	// Precomputed for the equal exponent case
	fpFormatPkg::sigT diffAB;
	fpFormatPkg::sigT diffBA;
	fpFormatPkg::sigT sumAB;

	logic expGtAB;
	logic expGtBA;
	logic sigGtAB;
	logic active;

	modport source (
		output signA, signB, effSub, expA, expB, sigA, sigB, shiftedA, shiftedB,
		output diffAB, diffBA, sumAB, expGtAB, expGtBA, sigGtAB, active
	);

	modport sink (
		input signA, signB, effSub, expA, expB, sigA, sigB, shiftedA, shiftedB,
		input diffAB, diffBA, sumAB, expGtAB, expGtBA, sigGtAB, active
	);

endinterface

// ==== src/fpExecPkg.sv ====
package fpExecPkg;

	// Bit 0 set selects add, clear selects subtract
	typedef enum logic [1:0] {
		opNone   = 2'b00,
		opAdd    = 2'b01,
		opSub    = 2'b10,
		opAddAlt = 2'b11
	} exOpE;

	// Result status as seen by the execute stage
	typedef enum logic [1:0] {
		statusReady = 2'b00, // Idle, no result
		statusOk    = 2'b01  // Result valid
	} exStatusE;

endpackage

// ==== src/fpFormatPkg.sv ====
package fpFormatPkg;

	// Binary16 field widths
	localparam int expW = 5;
	localparam int fracW = 10;
	localparam int halfW = 1 + expW + fracW;

	// Alignment shifts past this leave nothing of the smaller significand
	localparam int maxShift = 11;

	// One packed binary16 value
	typedef logic [halfW-1:0] halfT;

	// Exponent field as stored
	typedef logic [expW-1:0] expFieldT;

	// Working exponent, top bit flags overflow or underflow
	typedef logic [expW:0] expWideT;

	// Guard bit, hidden one, fraction
	typedef logic [fracW+1:0] sigT;

	// Infinity magnitude, sign bit left off
	localparam logic [expW+fracW-1:0] infMag = {{expW{1'b1}}, {fracW{1'b0}}};

endpackage
